// File: sprite_line_eval.f
hw/sprite_pkg.sv
hw/sprite_sync_ram.sv
hw/attr_port_arbiter.sv
hw/sprite_raster_collision.sv
hw/sprite_line_eval.sv
verification/tb_sprite_line_eval.sv

// File: Makefile
TOP := tb_sprite_line_eval

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sprite_line_eval.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: verification/tb_sprite_line_eval.sv
// testbench for the sprite line evaluator
// LFSR stimulus, shadow attribute table and hit-list reference model
// scan timing assertions, watchdog and result line

`timescale 1ns/1ps
`default_nettype none

module tb_sprite_line_eval
    import sprite_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DONE_DELAY      = SPRITES_TOTAL + 4;
    localparam int RANDOM_LINES    = 40;
    localparam int TOTAL_LINES     = RANDOM_LINES + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_LINES * (SPRITES_TOTAL + 40) + 200;

    logic                   clk;
    logic                   arst_n;
    logic                   host_we;
    logic [SPRITE_ID_W-1:0] host_index;
    sprite_attr_t           host_attr;
    logic                   host_busy;
    logic                   line_start;
    logic [RASTER_W-1:0]    raster_y;
    logic                   scan_done;
    logic [HIT_INDEX_W-1:0] hit_count;
    logic [HIT_INDEX_W-1:0] hit_rd_index;
    hit_entry_t             hit_rd_entry;

    sprite_attr_t shadow [SPRITES_TOTAL];
    hit_entry_t   exp_list [HIT_DEPTH];
    int           exp_count;
    logic [31:0]  lfsr_state = 32'h57626895;
    int           errors = 0;
    int           entries_checked = 0;
    int           lines_run = 0;
    logic         scan_pending;

    sprite_line_eval i_sprite_line_eval (
        .clk          (clk),
        .arst_n       (arst_n),
        .host_we      (host_we),
        .host_index   (host_index),
        .host_attr    (host_attr),
        .host_busy    (host_busy),
        .line_start   (line_start),
        .raster_y     (raster_y),
        .scan_done    (scan_done),
        .hit_count    (hit_count),
        .hit_rd_index (hit_rd_index),
        .hit_rd_entry (hit_rd_entry)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // tops spread over -8..55 so that rows 0..63 see a few hits and wraparound
    task automatic random_attr(output sprite_attr_t a);
        logic [31:0] r;
        take_bits(6, r);
        a.y_pos = RASTER_W'(r[5:0]) - RASTER_W'(8);
        take_bits(4, r);
        a.height = SPRITE_H_W'(r[3:0]) + SPRITE_H_W'(1);
        take_bits(1, r);
        a.flip_y = r[0];
        take_bits(1, r);
        a.wide = r[0];
    endtask

    task automatic host_write(input logic [SPRITE_ID_W-1:0] idx, input sprite_attr_t a);
        @(negedge clk);
        host_we    = 1'b1;
        host_index = idx;
        host_attr  = a;
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic load_entry(input logic [SPRITE_ID_W-1:0] idx, input sprite_attr_t a);
        host_write(idx, a);
        shadow[idx] = a;
    endtask

    task automatic load_random_table();
        sprite_attr_t a;
        for (int i = 0; i < SPRITES_TOTAL; i++) begin
            random_attr(a);
            load_entry(SPRITE_ID_W'(i), a);
        end
    endtask

    // sprites in table order, first MAX_HITS kept, terminator after them
    function automatic void build_expected(input logic [RASTER_W-1:0] row);
        logic [RASTER_W-1:0]   diff;
        logic [SPRITE_H_W-1:0] line_in_sprite;
        exp_count = 0;
        for (int i = 0; i < SPRITES_TOTAL; i++) begin
            diff = row - shadow[i].y_pos;
            if (diff < RASTER_W'(shadow[i].height) && exp_count < MAX_HITS) begin
                line_in_sprite = diff[SPRITE_H_W-1:0];
                if (shadow[i].flip_y) begin
                    line_in_sprite = shadow[i].height - SPRITE_H_W'(1) - diff[SPRITE_H_W-1:0];
                end
                exp_list[exp_count] = '{last: 1'b0, sprite_id: SPRITE_ID_W'(i),
                                        y_intersect: line_in_sprite[ROW_W-1:0],
                                        wide: shadow[i].wide};
                exp_count++;
            end
        end
        if (exp_count < MAX_HITS) begin
            exp_list[exp_count] = '{last: 1'b1, default: '0};
        end
    endfunction

    task automatic read_hit(input int idx, output hit_entry_t e);
        @(negedge clk);
        hit_rd_index = HIT_INDEX_W'(idx);
        @(negedge clk);
        e = hit_rd_entry;
    endtask

    task automatic check_line(input logic [RASTER_W-1:0] row);
        hit_entry_t got;
        int         last_slot;
        build_expected(row);
        a_hit_count: assert (hit_count == HIT_INDEX_W'(exp_count)) else begin
            errors++;
            $display("ERROR %0t: row %0d hit_count %0d, expected %0d", $time, row,
                     hit_count, exp_count);
        end
        last_slot = (exp_count < MAX_HITS) ? exp_count : exp_count - 1;
        for (int i = 0; i <= last_slot; i++) begin
            read_hit(i, got);
            entries_checked++;
            a_hit_entry: assert (got == exp_list[i]) else begin
                errors++;
                $display("ERROR %0t: row %0d entry %0d is %h, expected %h", $time, row, i,
                         got, exp_list[i]);
            end
        end
        // a full list leaves the terminator slot untouched
        if (exp_count == MAX_HITS) begin
            read_hit(MAX_HITS, got);
            a_no_terminator: assert (got.last !== 1'b1) else begin
                errors++;
                $display("ERROR %0t: row %0d terminator written to a full hit list", $time,
                         row);
            end
        end
        lines_run++;
    endtask

    // optional host write parked mid-scan, applied to the shadow after the check
    task automatic run_line(input logic [RASTER_W-1:0] row, input logic park,
                            input logic [SPRITE_ID_W-1:0] idx, input sprite_attr_t a);
        @(negedge clk);
        raster_y   = row;
        line_start = 1'b1;
        @(negedge clk);
        line_start = 1'b0;
        if (park) begin
            repeat (3) @(negedge clk);
            host_write(idx, a);
            a_parked_busy: assert (host_busy) else begin
                errors++;
                $display("host_busy stayed low for a host write issued during a scan");
            end
        end
        while (!scan_done) @(negedge clk);
        check_line(row);
        if (park) begin
            shadow[idx] = a;
        end
    endtask

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_pending <= 1'b0;
        end else if (line_start) begin
            scan_pending <= 1'b1;
        end else if (scan_done) begin
            scan_pending <= 1'b0;
        end
    end

    a_raster_hold: assert property (
        @(posedge clk) disable iff (!arst_n) (scan_pending && !scan_done) |-> $stable(raster_y)
    ) else begin
        errors++;
        $display("raster_y changed while a scan was in progress");
    end

    a_start_clears_done: assert property (
        @(posedge clk) disable iff (!arst_n) line_start |=> !scan_done
    ) else begin
        errors++;
        $display("ERROR %0t: scan_done still high after line_start", $time);
    end

    // sampled values trail the edge by one, hence the extra cycle
    a_done_timing: assert property (
        @(posedge clk) disable iff (!arst_n) line_start |-> ##(DONE_DELAY + 1) $rose(scan_done)
    ) else begin
        errors++;
        $display("ERROR %0t: scan_done did not rise %0d cycles after line_start", $time,
                 DONE_DELAY);
    end

    a_done_holds: assert property (
        @(posedge clk) disable iff (!arst_n) (scan_done && !line_start) |=> scan_done
    ) else begin
        errors++;
        $display("ERROR %0t: scan_done fell before the next line_start", $time);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        sprite_attr_t        a;
        logic [31:0]         r;
        logic [31:0]         n_writes;
        logic [RASTER_W-1:0] row;
        host_we      = 1'b0;
        host_index   = '0;
        host_attr    = '0;
        line_start   = 1'b0;
        raster_y     = '0;
        hit_rd_index = '0;
        arst_n       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        a_idle_after_reset: assert (!scan_done && !host_busy) else begin
            errors++;
            $display("ERROR %0t: scan_done or host_busy high after reset", $time);
        end

        // hits and terminator on a random table
        load_random_table();
        take_bits(6, r);
        run_line(RASTER_W'(r[5:0]), 1'b0, '0, '0);

        // every sprite on the row, list fills without a terminator
        row = RASTER_W'(100);
        for (int i = 0; i < SPRITES_TOTAL; i++) begin
            random_attr(a);
            a.y_pos = row;
            load_entry(SPRITE_ID_W'(i), a);
        end
        run_line(row, 1'b0, '0, '0);

        // write parked during a scan shows up on the following line
        // the last sprite is read well after the parked write arrives
        load_random_table();
        take_bits(6, r);
        row = RASTER_W'(r[5:0]);
        random_attr(a);
        a.y_pos = row;
        run_line(row, 1'b1, SPRITE_ID_W'(SPRITES_TOTAL - 1), a);
        run_line(row, 1'b0, '0, '0);

        for (int n = 0; n < RANDOM_LINES; n++) begin
            take_bits(2, n_writes);
            repeat (n_writes[1:0]) begin
                take_bits(4, r);
                random_attr(a);
                load_entry(r[SPRITE_ID_W-1:0], a);
            end
            take_bits(4, r);
            random_attr(a);
            take_bits(6, n_writes);
            run_line(RASTER_W'(n_writes[5:0]), (n % 4 == 3), r[SPRITE_ID_W-1:0], a);
        end

        repeat (4) @(negedge clk);
        $display("lines %0d, entries checked %0d, errors %0d", lines_run, entries_checked,
                 errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/sprite_line_eval.sv
// sprite line evaluator top level
// host port, attribute arbiter and memory, collision scanner, hit-list memory

`timescale 1ns/1ps
`default_nettype none

module sprite_line_eval
    import sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   host_we,
    input  logic [SPRITE_ID_W-1:0] host_index,
    input  sprite_attr_t           host_attr,
    output logic                   host_busy,

    input  logic                   line_start,
    input  logic [RASTER_W-1:0]    raster_y,
    output logic                   scan_done,
    output logic [HIT_INDEX_W-1:0] hit_count,

    input  logic [HIT_INDEX_W-1:0] hit_rd_index,
    output hit_entry_t             hit_rd_entry
);

    logic                   scan_active;
    logic [SPRITE_ID_W-1:0] sprite_test_id;

    logic                   attr_we;
    logic [SPRITE_ID_W-1:0] attr_waddr;
    sprite_attr_t           attr_wdata;
    logic [SPRITE_ID_W-1:0] attr_raddr;
    sprite_attr_t           attr_rd_data;

    logic                   hit_write_en;
    logic [HIT_INDEX_W-1:0] hit_list_index;
    hit_entry_t             hit_entry;

    attr_port_arbiter i_attr_port_arbiter (
        .clk            (clk),
        .arst_n         (arst_n),
        .host_we        (host_we),
        .host_index     (host_index),
        .host_attr      (host_attr),
        .host_busy      (host_busy),
        .scan_active    (scan_active),
        .sprite_test_id (sprite_test_id),
        .ram_we         (attr_we),
        .ram_waddr      (attr_waddr),
        .ram_wdata      (attr_wdata),
        .ram_raddr      (attr_raddr)
    );

    sprite_sync_ram #(
        .entry_t (sprite_attr_t),
        .DEPTH   (SPRITES_TOTAL)
    ) i_attr_ram (
        .clk   (clk),
        .we    (attr_we),
        .waddr (attr_waddr),
        .wdata (attr_wdata),
        .raddr (attr_raddr),
        .rdata (attr_rd_data)
    );

    sprite_raster_collision i_sprite_raster_collision (
        .clk            (clk),
        .arst_n         (arst_n),
        .restart        (line_start),
        .raster_y       (raster_y),
        .sprite_test_id (sprite_test_id),
        .scan_active    (scan_active),
        .attr           (attr_rd_data),
        .hit_write_en   (hit_write_en),
        .hit_list_index (hit_list_index),
        .hit_entry      (hit_entry),
        .hit_count      (hit_count),
        .finished       (scan_done)
    );

    // read side is free for the outside port
    sprite_sync_ram #(
        .entry_t (hit_entry_t),
        .DEPTH   (HIT_DEPTH)
    ) i_hit_ram (
        .clk   (clk),
        .we    (hit_write_en),
        .waddr (hit_list_index),
        .wdata (hit_entry),
        .raddr (hit_rd_index),
        .rdata (hit_rd_entry)
    );

endmodule

`default_nettype wire

// File: hw/sprite_raster_collision.sv
// pipelined raster collision scanner
// walks the attribute table, tests each sprite against the raster row
// and writes the hit list followed by a terminator

`timescale 1ns/1ps
`default_nettype none

module sprite_raster_collision
    import sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   restart,
    input  logic [RASTER_W-1:0]    raster_y,

    // attribute read
    output logic [SPRITE_ID_W-1:0] sprite_test_id,
    output logic                   scan_active,
    input  sprite_attr_t           attr,

    // hit list write
    output logic                   hit_write_en,
    output logic [HIT_INDEX_W-1:0] hit_list_index,
    output hit_entry_t             hit_entry,

    output logic [HIT_INDEX_W-1:0] hit_count,
    output logic                   finished
);

    logic [RASTER_W-1:0]    raster_y_r;
    logic                   busy;
    logic [SCAN_STEP_W-1:0] step;

    // stage 1, attributes of the sprite read last cycle
    logic                   s1_valid;
    logic [SPRITE_ID_W-1:0] s1_id;
    logic [RASTER_W-1:0]    s1_diff;
    logic                   s1_hit;

    // stage 2, registered compare
    logic                   s2_valid;
    logic                   s2_hit;
    logic [SPRITE_ID_W-1:0] s2_id;
    logic [ROW_W-1:0]       s2_row;
    logic [SPRITE_H_W-1:0]  s2_height;
    logic                   s2_flip;
    logic                   s2_wide;
    logic [SPRITE_H_W-1:0]  s2_flip_row;
    logic [ROW_W-1:0]       s2_row_out;

    logic                   list_open;
    logic                   collision_wr;
    logic                   term_wr;

    // wraparound difference, so sprites crossing row 0 still match
    assign s1_diff = raster_y_r - attr.y_pos;
    assign s1_hit  = s1_diff < RASTER_W'(attr.height);

    assign s2_flip_row = s2_height - SPRITE_H_W'(1) - SPRITE_H_W'(s2_row);
    assign s2_row_out  = s2_flip ? s2_flip_row[ROW_W-1:0] : s2_row;

    assign list_open    = hit_count < MAX_HITS;
    assign collision_wr = s2_valid && s2_hit && list_open;
    assign term_wr      = busy && (step == SCAN_STEP_W'(SCAN_LATENCY - 1)) && list_open;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy           <= 1'b0;
            scan_active    <= 1'b0;
            sprite_test_id <= '0;
            step           <= '0;
            finished       <= 1'b0;
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            hit_write_en   <= 1'b0;
            hit_count      <= '0;
            hit_list_index <= '0;
        end else if (restart) begin
            busy           <= 1'b1;
            scan_active    <= 1'b1;
            sprite_test_id <= '0;
            step           <= '0;
            finished       <= 1'b0;
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            hit_write_en   <= 1'b0;
            hit_count      <= '0;
            hit_list_index <= '0;
        end else begin
            s1_valid     <= scan_active;
            s2_valid     <= s1_valid;
            hit_write_en <= collision_wr || term_wr;

            if (scan_active) begin
                sprite_test_id <= sprite_test_id + 1'b1;
                if (sprite_test_id == SPRITE_ID_W'(SPRITES_TOTAL - 1)) begin
                    scan_active <= 1'b0;
                end
            end

            // fixed-length walk, the pipeline has drained by the last step
            if (busy) begin
                step <= step + 1'b1;
                if (step == SCAN_STEP_W'(SCAN_LATENCY - 1)) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end
            end

            if (collision_wr || term_wr) begin
                hit_list_index <= hit_count;
            end
            if (collision_wr) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            raster_y_r <= raster_y;
        end

        s1_id <= sprite_test_id;

        s2_id     <= s1_id;
        s2_hit    <= s1_hit;
        s2_row    <= s1_diff[ROW_W-1:0];
        s2_height <= attr.height;
        s2_flip   <= attr.flip_y;
        s2_wide   <= attr.wide;

        if (collision_wr) begin
            hit_entry <= '{last: 1'b0, sprite_id: s2_id, y_intersect: s2_row_out,
                           wide: s2_wide};
        end else if (term_wr) begin
            hit_entry <= '{last: 1'b1, default: '0};
        end
    end

    a_restart_clears: assert property (
        @(posedge clk) disable iff (!arst_n) restart |=> (!finished && !hit_write_en)
    ) else $error("finished or hit write still high after restart");

    a_index_range: assert property (
        @(posedge clk) disable iff (!arst_n) hit_list_index <= MAX_HITS
    ) else $error("hit list index %0d past the terminator slot", hit_list_index);

    // the height seen at stage 2 belongs to the entry written one cycle later
    a_row_in_height: assert property (
        @(posedge clk) disable iff (!arst_n)
        (hit_write_en && !hit_entry.last) |-> (hit_entry.y_intersect < $past(s2_height))
    ) else $error("sprite %0d row %0d outside its height", hit_entry.sprite_id,
                  hit_entry.y_intersect);

endmodule

`default_nettype wire

// File: hw/attr_port_arbiter.sv
// attribute memory arbitration between scanner reads and host writes
// one-entry buffer parks a host write that arrives during a scan

`timescale 1ns/1ps
`default_nettype none

module attr_port_arbiter
    import sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    // host load port
    input  logic                   host_we,
    input  logic [SPRITE_ID_W-1:0] host_index,
    input  sprite_attr_t           host_attr,
    output logic                   host_busy,

    // scanner side
    input  logic                   scan_active,
    input  logic [SPRITE_ID_W-1:0] sprite_test_id,

    // memory side
    output logic                   ram_we,
    output logic [SPRITE_ID_W-1:0] ram_waddr,
    output sprite_attr_t           ram_wdata,
    output logic [SPRITE_ID_W-1:0] ram_raddr
);

    logic                   park_valid;
    logic [SPRITE_ID_W-1:0] park_index;
    sprite_attr_t           park_attr;

    logic commit_park;
    logic pass_host;
    logic park_host;

    // parked write drains in the first idle cycle
    assign commit_park = park_valid && !scan_active;
    assign pass_host   = host_we && !scan_active && !park_valid;
    // a strobe meeting a commit is parked behind it, keeping program order
    assign park_host   = host_we && (scan_active || park_valid);

    assign ram_we    = commit_park || pass_host;
    assign ram_waddr = park_valid ? park_index : host_index;
    assign ram_wdata = park_valid ? park_attr : host_attr;

    // the read port belongs to the scanner
    assign ram_raddr = sprite_test_id;

    // buffer can take a new write again in its commit cycle
    assign host_busy = park_valid && scan_active;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            park_valid <= 1'b0;
        end else if (park_host) begin
            park_valid <= 1'b1;
        end else if (commit_park) begin
            park_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (park_host) begin
            park_index <= host_index;
            park_attr  <= host_attr;
        end
    end

    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n) host_we |-> !host_busy
    ) else $error("host write strobe while the parked buffer is busy");

    a_no_write_during_scan: assert property (
        @(posedge clk) disable iff (!arst_n) scan_active |-> !ram_we
    ) else $error("attribute memory written while the scanner is reading");

endmodule

`default_nettype wire

// File: hw/sprite_sync_ram.sv
// single-clock RAM, one write port and one registered read port
// entry payload chosen by a type parameter

`timescale 1ns/1ps
`default_nettype none

module sprite_sync_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // write lands at the edge, read returns the old word on a collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    // depth need not be a power of two, so the top addresses are holes
    a_waddr_in_range: assert property (
        @(posedge clk) we |-> (waddr < DEPTH)
    ) else $error("write to address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

// File: hw/sprite_pkg.sv
// shared constants for the sprite line evaluator
// sprite attribute entry and hit-list entry types
// scanner pipeline latency

`default_nettype none

package sprite_pkg;

    // attribute table
    localparam int SPRITES_TOTAL = 16;
    localparam int SPRITE_ID_W   = 4;

    // hit list, one extra slot holds the terminator
    localparam int MAX_HITS    = 8;
    localparam int HIT_INDEX_W = 4;
    localparam int HIT_DEPTH   = MAX_HITS + 1;

    // raster geometry
    localparam int RASTER_W   = 9;
    localparam int SPRITE_H_W = 5;
    localparam int ROW_W      = 4;

    // read index to attribute data
    localparam int ATTR_READ_LATENCY = 1;

    // line_start to scan_done, read + compare + write + terminator
    localparam int SCAN_LATENCY = SPRITES_TOTAL + ATTR_READ_LATENCY + 3;
    localparam int SCAN_STEP_W  = $clog2(SCAN_LATENCY + 1);

    typedef struct packed {
        logic [RASTER_W-1:0]   y_pos;
        logic [SPRITE_H_W-1:0] height;
        logic                  flip_y;
        logic                  wide;
    } sprite_attr_t;

    typedef struct packed {
        logic                   last;
        logic [SPRITE_ID_W-1:0] sprite_id;
        logic [ROW_W-1:0]       y_intersect;
        logic                   wide;
    } hit_entry_t;

endpackage

`default_nettype wire
